/* design/eth_udp_pkg.sv */
// ============================
// Shared types, constants and register offsets for the UDP receive path
// ============================
`default_nettype none

package eth_udp_pkg;

  // MAC address as one word or two register halves
  typedef struct packed {
    logic [23:0] high;
    logic [23:0] low;
  } mac_halves_t;

  typedef union packed {
    logic [47:0] addr;
    mac_halves_t half;
  } mac_addr_u;

  typedef logic [31:0] ipv4_addr_t;
  typedef logic [15:0] udp_len_t;

  // One byte of the receive stream
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
    logic       last;
    logic       err;
  } rx_beat_t;

  typedef struct packed {
    mac_addr_u   dest_mac;
    mac_addr_u   src_mac;
    logic [15:0] ethertype;
  } eth_hdr_t;

  typedef struct packed {
    mac_addr_u  mac;
    ipv4_addr_t ip;
  } local_cfg_t;

  // Sender info of an accepted frame
  typedef struct packed {
    mac_addr_u  src_mac;
    ipv4_addr_t src_ip;
    udp_len_t   udp_len;
  } udp_rx_rec_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [5:0]  addr;
    logic [31:0] wdata;
  } csr_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
  } csr_rsp_t;

  localparam int          ETH_HDR_BYTES  = 14;
  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam logic [7:0]  IP_VER_IHL     = 8'h45;
  localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;
  // IP plus UDP header bytes
  localparam int          UDP_HDR_END    = 28;
  localparam logic [47:0] MAC_BROADCAST  = 48'hFFFF_FFFF_FFFF;

  localparam logic [5:0] CSR_MAC_LOW       = 6'h00;
  localparam logic [5:0] CSR_MAC_HIGH      = 6'h04;
  localparam logic [5:0] CSR_IP            = 6'h08;
  localparam logic [5:0] CSR_RECV_MAC_LOW  = 6'h0C;
  localparam logic [5:0] CSR_RECV_MAC_HIGH = 6'h10;
  localparam logic [5:0] CSR_RECV_IP       = 6'h14;
  localparam logic [5:0] CSR_RECV_UDP_LEN  = 6'h18;
  localparam logic [5:0] CSR_IRQ           = 6'h1C;

endpackage

`default_nettype wire

/* design/eth_frame_parser.sv */
// ============================
// Ethernet header stripper that forwards the payload stream
// ============================
`timescale 1ns/10ps
`default_nettype none

module eth_frame_parser (
  input  wire                   clk,
  input  wire                   rst,
  input  eth_udp_pkg::rx_beat_t i_rx,
  output eth_udp_pkg::rx_beat_t o_payload,
  output eth_udp_pkg::eth_hdr_t o_eth_hdr
);

  localparam int CNT_W = $clog2(eth_udp_pkg::ETH_HDR_BYTES + 1);
  localparam logic [CNT_W-1:0] HDR_END = CNT_W'(eth_udp_pkg::ETH_HDR_BYTES);

  logic [CNT_W-1:0]      cnt_q;
  logic                  in_hdr;
  eth_udp_pkg::eth_hdr_t hdr_q;
  logic                  pl_valid_q;
  logic [7:0]            pl_data_q;
  logic                  pl_last_q;
  logic                  pl_err_q;

  assign in_hdr = (cnt_q < HDR_END);

  // Header byte position that parks at HDR_END for payload
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q <= '0;
    end else if (i_rx.valid) begin
      if (i_rx.last) begin
        cnt_q <= '0;
      end else if (in_hdr) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // First wire byte ends up in the MSBs (dest MAC)
  always_ff @(posedge clk) begin
    if (i_rx.valid && in_hdr) begin
      hdr_q <= eth_udp_pkg::eth_hdr_t'({hdr_q[103:0], i_rx.data});
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pl_valid_q <= 1'b0;
    end else begin
      pl_valid_q <= i_rx.valid && !in_hdr;
    end
  end

  always_ff @(posedge clk) begin
    pl_data_q <= i_rx.data;
    pl_last_q <= i_rx.last;
    pl_err_q  <= i_rx.err;
  end

  assign o_payload.valid = pl_valid_q;
  assign o_payload.data  = pl_data_q;
  assign o_payload.last  = pl_last_q;
  assign o_payload.err   = pl_err_q;
  assign o_eth_hdr       = hdr_q;

endmodule

`default_nettype wire

/* design/ip_udp_parser.sv */
// ============================
// IPv4 and UDP header parser with address filters
// ============================
`timescale 1ns/10ps
`default_nettype none

module ip_udp_parser (
  input  wire                      clk,
  input  wire                      rst,
  input  eth_udp_pkg::rx_beat_t    i_payload,
  input  eth_udp_pkg::eth_hdr_t    i_eth_hdr,
  input  eth_udp_pkg::local_cfg_t  i_cfg,
  output eth_udp_pkg::udp_rx_rec_t o_rec,
  output logic                     o_rec_valid
);

  localparam int CNT_W = $clog2(eth_udp_pkg::UDP_HDR_END + 1);
  localparam logic [CNT_W-1:0] HDR_END = CNT_W'(eth_udp_pkg::UDP_HDR_END);

  // Byte offsets from the start of the IP header
  localparam logic [CNT_W-1:0] OFF_VER_IHL  = 0;
  localparam logic [CNT_W-1:0] OFF_PROTO    = 9;
  localparam logic [CNT_W-1:0] OFF_SRC_IP   = 12;
  localparam logic [CNT_W-1:0] OFF_DST_IP   = 16;
  localparam logic [CNT_W-1:0] OFF_UDP_SRC  = 20;
  localparam logic [CNT_W-1:0] OFF_UDP_LEN  = 24;
  localparam logic [CNT_W-1:0] OFF_UDP_CSUM = 26;

  logic [CNT_W-1:0]         cnt_q;
  logic                     ver_ok_q;
  logic                     proto_ok_q;
  eth_udp_pkg::ipv4_addr_t  src_ip_q;
  eth_udp_pkg::ipv4_addr_t  dst_ip_q;
  eth_udp_pkg::udp_len_t    udp_len_q;
  logic                     eth_ok;
  logic                     hdr_done;
  logic                     accept;
  logic                     rec_valid_q;
  eth_udp_pkg::udp_rx_rec_t rec_q;

  assign eth_ok = ((i_eth_hdr.dest_mac.addr == i_cfg.mac.addr) ||
                   (i_eth_hdr.dest_mac.addr == eth_udp_pkg::MAC_BROADCAST)) &&
                  (i_eth_hdr.ethertype == eth_udp_pkg::ETHERTYPE_IPV4);

  // Current byte closes the UDP header or lies past it
  assign hdr_done = (cnt_q >= HDR_END - 1'b1);

  assign accept = i_payload.valid && i_payload.last && !i_payload.err &&
                  eth_ok && hdr_done && ver_ok_q && proto_ok_q &&
                  (dst_ip_q == i_cfg.ip);

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q      <= '0;
      ver_ok_q   <= 1'b0;
      proto_ok_q <= 1'b0;
    end else if (i_payload.valid) begin
      if (i_payload.last) begin
        cnt_q <= '0;
      end else if (cnt_q < HDR_END) begin
        cnt_q <= cnt_q + 1'b1;
      end
      if (cnt_q == OFF_VER_IHL) begin
        ver_ok_q <= (i_payload.data == eth_udp_pkg::IP_VER_IHL);
      end
      if (cnt_q == OFF_PROTO) begin
        proto_ok_q <= (i_payload.data == eth_udp_pkg::IP_PROTO_UDP);
      end
    end
  end

  // Big-endian header fields shifted in a byte at a time
  always_ff @(posedge clk) begin
    if (i_payload.valid) begin
      if (cnt_q >= OFF_SRC_IP && cnt_q < OFF_DST_IP) begin
        src_ip_q <= {src_ip_q[23:0], i_payload.data};
      end
      if (cnt_q >= OFF_DST_IP && cnt_q < OFF_UDP_SRC) begin
        dst_ip_q <= {dst_ip_q[23:0], i_payload.data};
      end
      if (cnt_q >= OFF_UDP_LEN && cnt_q < OFF_UDP_CSUM) begin
        udp_len_q <= {udp_len_q[7:0], i_payload.data};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rec_valid_q <= 1'b0;
    end else begin
      rec_valid_q <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rec_q.src_mac <= i_eth_hdr.src_mac;
      rec_q.src_ip  <= src_ip_q;
      rec_q.udp_len <= udp_len_q;
    end
  end

  assign o_rec       = rec_q;
  assign o_rec_valid = rec_valid_q;

endmodule

`default_nettype wire

/* design/udp_rx_capture.sv */
// ============================
// Last accepted record and packet interrupt
// ============================
`timescale 1ns/10ps
`default_nettype none

module udp_rx_capture (
  input  wire                      clk,
  input  wire                      rst,
  input  eth_udp_pkg::udp_rx_rec_t i_rec,
  input  wire                      i_rec_valid,
  input  wire                      i_clear_irq,
  output eth_udp_pkg::udp_rx_rec_t o_rec,
  output logic                     o_irq
);

  eth_udp_pkg::udp_rx_rec_t rec_q;
  logic                     irq_q;

  // Clear beats a new record for the flag only
  always_ff @(posedge clk) begin
    if (rst) begin
      rec_q <= '0;
      irq_q <= 1'b0;
    end else begin
      if (i_rec_valid) begin
        rec_q <= i_rec;
      end
      if (i_clear_irq) begin
        irq_q <= 1'b0;
      end else if (i_rec_valid) begin
        irq_q <= 1'b1;
      end
    end
  end

  assign o_rec = rec_q;
  assign o_irq = irq_q;

endmodule

`default_nettype wire

/* design/eth_csr.sv */
// ============================
// Register block for local address config, record readback and irq clear
// ============================
`timescale 1ns/10ps
`default_nettype none

module eth_csr #(
  parameter logic [47:0] LOCAL_MAC_RESET = 48'h0,
  parameter logic [31:0] LOCAL_IP_RESET  = 32'h0
) (
  input  wire                      clk,
  input  wire                      rst,
  input  eth_udp_pkg::csr_req_t    i_csr_req,
  output eth_udp_pkg::csr_rsp_t    o_csr_rsp,
  output eth_udp_pkg::local_cfg_t  o_cfg,
  output logic                     o_clear_irq,
  input  eth_udp_pkg::udp_rx_rec_t i_rec,
  input  wire                      i_irq
);

  eth_udp_pkg::mac_addr_u  mac_q;
  eth_udp_pkg::ipv4_addr_t ip_q;
  logic                    wr_en;
  logic                    rd_en;
  logic [31:0]             rd_data;
  logic                    rsp_valid_q;
  logic [31:0]             rdata_q;

  assign wr_en = i_csr_req.valid && i_csr_req.write;
  assign rd_en = i_csr_req.valid && !i_csr_req.write;

  // Same edge as the write so a following read sees the flag low
  assign o_clear_irq = wr_en && (i_csr_req.addr == eth_udp_pkg::CSR_IRQ);

  always_ff @(posedge clk) begin
    if (rst) begin
      mac_q.addr <= LOCAL_MAC_RESET;
      ip_q       <= LOCAL_IP_RESET;
    end else if (wr_en) begin
      case (i_csr_req.addr)
        eth_udp_pkg::CSR_MAC_LOW:  mac_q.half.low  <= i_csr_req.wdata[23:0];
        eth_udp_pkg::CSR_MAC_HIGH: mac_q.half.high <= i_csr_req.wdata[23:0];
        eth_udp_pkg::CSR_IP:       ip_q            <= i_csr_req.wdata;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (i_csr_req.addr)
      eth_udp_pkg::CSR_MAC_LOW:       rd_data = {8'h00, mac_q.half.low};
      eth_udp_pkg::CSR_MAC_HIGH:      rd_data = {8'h00, mac_q.half.high};
      eth_udp_pkg::CSR_IP:            rd_data = ip_q;
      eth_udp_pkg::CSR_RECV_MAC_LOW:  rd_data = {8'h00, i_rec.src_mac.half.low};
      eth_udp_pkg::CSR_RECV_MAC_HIGH: rd_data = {8'h00, i_rec.src_mac.half.high};
      eth_udp_pkg::CSR_RECV_IP:       rd_data = i_rec.src_ip;
      eth_udp_pkg::CSR_RECV_UDP_LEN:  rd_data = {16'h0000, i_rec.udp_len};
      eth_udp_pkg::CSR_IRQ:           rd_data = {31'd0, i_irq};
      default:                        rd_data = '0;
    endcase
  end

  // Every request answered one cycle later
  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= i_csr_req.valid;
    end
  end

  // Writes answer with zero
  always_ff @(posedge clk) begin
    rdata_q <= rd_en ? rd_data : '0;
  end

  assign o_csr_rsp.valid = rsp_valid_q;
  assign o_csr_rsp.rdata = rdata_q;
  assign o_cfg.mac       = mac_q;
  assign o_cfg.ip        = ip_q;

endmodule

`default_nettype wire

/* design/eth_udp_rx_top.sv */
// ============================
// UDP receive path top level
// ============================
`timescale 1ns/10ps
`default_nettype none

module eth_udp_rx_top #(
  parameter logic [47:0] LOCAL_MAC_RESET = 48'h0,
  parameter logic [31:0] LOCAL_IP_RESET  = 32'h0
) (
  input  wire                   clk,
  input  wire                   rst,
  input  eth_udp_pkg::rx_beat_t i_rx,
  input  eth_udp_pkg::csr_req_t i_csr_req,
  output eth_udp_pkg::csr_rsp_t o_csr_rsp,
  output logic                  o_pkt_recv
);

  eth_udp_pkg::local_cfg_t  cfg;
  eth_udp_pkg::rx_beat_t    payload;
  eth_udp_pkg::eth_hdr_t    eth_hdr;
  eth_udp_pkg::udp_rx_rec_t parsed_rec;
  logic                     parsed_rec_valid;
  eth_udp_pkg::udp_rx_rec_t held_rec;
  logic                     clear_irq;

  eth_csr #(
    .LOCAL_MAC_RESET (LOCAL_MAC_RESET),
    .LOCAL_IP_RESET  (LOCAL_IP_RESET)
  ) i_eth_csr (
    .clk         (clk),
    .rst         (rst),
    .i_csr_req   (i_csr_req),
    .o_csr_rsp   (o_csr_rsp),
    .o_cfg       (cfg),
    .o_clear_irq (clear_irq),
    .i_rec       (held_rec),
    .i_irq       (o_pkt_recv)
  );

  eth_frame_parser i_eth_frame_parser (
    .clk       (clk),
    .rst       (rst),
    .i_rx      (i_rx),
    .o_payload (payload),
    .o_eth_hdr (eth_hdr)
  );

  ip_udp_parser i_ip_udp_parser (
    .clk         (clk),
    .rst         (rst),
    .i_payload   (payload),
    .i_eth_hdr   (eth_hdr),
    .i_cfg       (cfg),
    .o_rec       (parsed_rec),
    .o_rec_valid (parsed_rec_valid)
  );

  udp_rx_capture i_udp_rx_capture (
    .clk         (clk),
    .rst         (rst),
    .i_rec       (parsed_rec),
    .i_rec_valid (parsed_rec_valid),
    .i_clear_irq (clear_irq),
    .o_rec       (held_rec),
    .o_irq       (o_pkt_recv)
  );

endmodule

`default_nettype wire

/* dv/eth_udp_rx_assertions.sv */
// ==============================
// Register bus and interrupt assertions
// ==============================
`timescale 1ns/10ps
`default_nettype none

module eth_udp_rx_assertions (
  input wire                   clk,
  input wire                   rst,
  input eth_udp_pkg::csr_req_t i_csr_req,
  input eth_udp_pkg::csr_rsp_t i_csr_rsp,
  input wire                   i_pkt_recv
);

  logic irq_write;

  assign irq_write = i_csr_req.valid && i_csr_req.write &&
                     (i_csr_req.addr == eth_udp_pkg::CSR_IRQ);

  rsp_after_req: assert property (@(posedge clk) disable iff (rst)
    i_csr_req.valid |=> i_csr_rsp.valid)
    else $error("register response missing one cycle after a request");

  // Clear wins over a new record for the flag
  irq_low_after_clear: assert property (@(posedge clk) disable iff (rst)
    irq_write |=> !i_pkt_recv)
    else $error("packet interrupt still high after an IRQ register write");

  no_rsp_without_req: assert property (@(posedge clk) disable iff (rst)
    !i_csr_req.valid |=> !i_csr_rsp.valid)
    else $error("register response given without a request");

endmodule

bind eth_udp_rx_top eth_udp_rx_assertions i_eth_udp_rx_assertions (
  .clk        (clk),
  .rst        (rst),
  .i_csr_req  (i_csr_req),
  .i_csr_rsp  (o_csr_rsp),
  .i_pkt_recv (o_pkt_recv)
);

`default_nettype wire

/* dv/tb_eth_udp_rx.sv */
// ==============================
// Testbench for the UDP receive path
// Frame table, register access and checks
// ==============================
`timescale 1ns/10ps
`default_nettype none

module tb_eth_udp_rx;

  localparam int          CLK_PERIOD = 4;
  localparam int          NUM_ROWS   = 12;
  localparam logic [31:0] SEED       = 32'h47d8;
  localparam logic [47:0] MY_MAC     = 48'h0200_00AB_CDEF;
  localparam logic [31:0] MY_IP      = 32'hC0A8_0164;
  localparam logic [47:0] BCAST      = 48'hFFFF_FFFF_FFFF;

  typedef struct packed {
    logic [47:0] dest_mac;
    logic [47:0] src_mac;
    logic [15:0] ethertype;
    logic [7:0]  ver_ihl;
    logic [7:0]  proto;
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [15:0] udp_len;
    logic [7:0]  payload_len;
    logic        err;
    logic [7:0]  cut_len;
    logic        accept;
  } row_t;

  logic                     clk = 1'b0;
  logic                     rst;
  eth_udp_pkg::rx_beat_t    rx;
  eth_udp_pkg::csr_req_t    csr_req;
  eth_udp_pkg::csr_rsp_t    csr_rsp;
  logic                     pkt_recv;
  row_t                     rows [NUM_ROWS];
  logic [7:0]               frame_q [$];
  eth_udp_pkg::udp_rx_rec_t exp_rec;

  eth_udp_rx_top i_eth_udp_rx_top (
    .clk        (clk),
    .rst        (rst),
    .i_rx       (rx),
    .i_csr_req  (csr_req),
    .o_csr_rsp  (csr_rsp),
    .o_pkt_recv (pkt_recv)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_mac(input string name, input eth_udp_pkg::mac_addr_u exp,
                           input eth_udp_pkg::mac_addr_u act);
    if (act.addr !== exp.addr) begin
      abort_run($sformatf("[ERROR] %s: expected %h, got %h", name, exp.addr, act.addr));
    end
  endtask

  task automatic check_ip(input string name, input eth_udp_pkg::ipv4_addr_t exp,
                          input eth_udp_pkg::ipv4_addr_t act);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %s: expected %h, got %h", name, exp, act));
    end
  endtask

  task automatic check_len(input string name, input eth_udp_pkg::udp_len_t exp,
                           input eth_udp_pkg::udp_len_t act);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %s: expected %h, got %h", name, exp, act));
    end
  endtask

  task automatic check_irq(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %s: expected %h, got %h", name, exp, act));
    end
  endtask

  task automatic check_rdata(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %s: expected %h, got %h", name, exp, act));
    end
  endtask

  // One request with its response sampled a cycle later
  task automatic csr_access(input logic write, input logic [5:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge clk);
    csr_req <= '{valid: 1'b1, write: write, addr: addr, wdata: wdata};
    @(posedge clk);
    csr_req <= '0;
    @(negedge clk);
    if (csr_rsp.valid !== 1'b1) begin
      abort_run($sformatf("No register response one cycle after the request to offset %h", addr));
    end
    rdata = csr_rsp.rdata;
  endtask

  task automatic csr_write(input logic [5:0] addr, input logic [31:0] wdata);
    logic [31:0] rd;
    csr_access(1'b1, addr, wdata, rd);
    check_rdata("o_csr_rsp.rdata (write)", 32'h0, rd);
  endtask

  task automatic csr_read(input logic [5:0] addr, output logic [31:0] rdata);
    csr_access(1'b0, addr, 32'h0, rdata);
  endtask

  task automatic read_mac(input logic [5:0] lo_addr, input logic [5:0] hi_addr,
                          output eth_udp_pkg::mac_addr_u mac);
    logic [31:0] lo;
    logic [31:0] hi;
    csr_read(lo_addr, lo);
    csr_read(hi_addr, hi);
    mac.half.low  = lo[23:0];
    mac.half.high = hi[23:0];
  endtask

  task automatic check_record();
    eth_udp_pkg::mac_addr_u mac_rd;
    logic [31:0]            rd;
    read_mac(eth_udp_pkg::CSR_RECV_MAC_LOW, eth_udp_pkg::CSR_RECV_MAC_HIGH, mac_rd);
    check_mac("recv MAC", exp_rec.src_mac, mac_rd);
    csr_read(eth_udp_pkg::CSR_RECV_IP, rd);
    check_ip("recv IP", exp_rec.src_ip, rd);
    csr_read(eth_udp_pkg::CSR_RECV_UDP_LEN, rd);
    check_len("recv UDP length", exp_rec.udp_len, rd[15:0]);
  endtask

  task automatic push_bytes(input logic [47:0] value, input int nbytes);
    for (int i = nbytes - 1; i >= 0; i--) begin
      frame_q.push_back(value[8*i +: 8]);
    end
  endtask

  // Wire order with the most significant byte of every field first
  task automatic build_frame(input row_t r);
    frame_q.delete();
    push_bytes(r.dest_mac, 6);
    push_bytes(r.src_mac, 6);
    push_bytes(r.ethertype, 2);
    push_bytes(r.ver_ihl, 1);
    push_bytes(8'h00, 1);
    push_bytes(16'd20 + r.udp_len, 2);
    push_bytes(32'h1234_4000, 4);
    push_bytes(8'd64, 1);
    push_bytes(r.proto, 1);
    // IP checksum left at zero
    push_bytes(16'h0000, 2);
    push_bytes(r.src_ip, 4);
    push_bytes(r.dst_ip, 4);
    push_bytes(32'h1F90_1F91, 4);
    push_bytes(r.udp_len, 2);
    push_bytes(16'h0000, 2);
    for (int i = 0; i < r.payload_len; i++) begin
      frame_q.push_back(8'($urandom));
    end
    if (r.cut_len != 0) begin
      while (frame_q.size() > r.cut_len) begin
        void'(frame_q.pop_back());
      end
    end
  endtask

  task automatic send_frame(input logic err);
    int unsigned gap;
    logic        last_byte;
    for (int i = 0; i < frame_q.size(); i++) begin
      last_byte = (i == frame_q.size() - 1);
      @(posedge clk);
      rx <= '{valid: 1'b1, data: frame_q[i], last: last_byte, err: err && last_byte};
      if (!last_byte) begin
        gap = $urandom % 2;
        repeat (gap) begin
          @(posedge clk);
          rx <= '0;
        end
      end
    end
    @(posedge clk);
    rx <= '0;
  endtask

  // Flag stays low two edges after the last byte and rises on the third
  task automatic check_irq_timing(input logic irq_due);
    @(posedge clk);
    @(negedge clk);
    check_irq("o_pkt_recv", 1'b0, pkt_recv);
    @(posedge clk);
    @(negedge clk);
    check_irq("o_pkt_recv", irq_due, pkt_recv);
  endtask

  task automatic load_table();
    rows[0]  = '{MY_MAC, 48'h0011_2233_4455, 16'h0800, 8'h45, 8'd17,
                 32'hC0A8_010A, MY_IP, 16'd16, 8'd8, 1'b0, 8'd0, 1'b1};
    rows[1]  = '{BCAST, 48'h6677_8899_AABB, 16'h0800, 8'h45, 8'd17,
                 32'h0A00_0001, MY_IP, 16'd20, 8'd12, 1'b0, 8'd0, 1'b1};
    rows[2]  = '{48'h0200_00AB_CDEE, 48'h1010_1010_1010, 16'h0800, 8'h45, 8'd17,
                 32'h0101_0101, MY_IP, 16'd12, 8'd4, 1'b0, 8'd0, 1'b0};
    rows[3]  = '{MY_MAC, 48'h2020_2020_2020, 16'h0806, 8'h45, 8'd17,
                 32'h0202_0202, MY_IP, 16'd12, 8'd4, 1'b0, 8'd0, 1'b0};
    rows[4]  = '{MY_MAC, 48'h3030_3030_3030, 16'h0800, 8'h46, 8'd17,
                 32'h0303_0303, MY_IP, 16'd12, 8'd4, 1'b0, 8'd0, 1'b0};
    rows[5]  = '{MY_MAC, 48'h4040_4040_4040, 16'h0800, 8'h45, 8'd6,
                 32'h0404_0404, MY_IP, 16'd12, 8'd4, 1'b0, 8'd0, 1'b0};
    rows[6]  = '{MY_MAC, 48'h5050_5050_5050, 16'h0800, 8'h45, 8'd17,
                 32'h0505_0505, 32'hC0A8_0165, 16'd12, 8'd4, 1'b0, 8'd0, 1'b0};
    rows[7]  = '{MY_MAC, 48'h6060_6060_6060, 16'h0800, 8'h45, 8'd17,
                 32'h0606_0606, MY_IP, 16'd12, 8'd4, 1'b1, 8'd0, 1'b0};
    // Cut inside the Ethernet header, then one byte short of the UDP header
    rows[8]  = '{MY_MAC, 48'h7070_7070_7070, 16'h0800, 8'h45, 8'd17,
                 32'h0707_0707, MY_IP, 16'd12, 8'd4, 1'b0, 8'd10, 1'b0};
    rows[9]  = '{MY_MAC, 48'h8080_8080_8080, 16'h0800, 8'h45, 8'd17,
                 32'h0808_0808, MY_IP, 16'd12, 8'd4, 1'b0, 8'd41, 1'b0};
    rows[10] = '{MY_MAC, 48'h00A0_C912_3456, 16'h0800, 8'h45, 8'd17,
                 32'hC0A8_0A0B, MY_IP, 16'd8, 8'd0, 1'b0, 8'd0, 1'b1};
    rows[11] = '{BCAST, 48'hACDE_4800_1122, 16'h0800, 8'h45, 8'd17,
                 32'h0A0A_0A0A, MY_IP, 16'd24, 8'd16, 1'b0, 8'd0, 1'b1};
  endtask

  initial begin
    #(NUM_ROWS * 200 * CLK_PERIOD);
    abort_run($sformatf("Timeout: the run did not finish within %0d clock cycles",
                        NUM_ROWS * 200));
  end

  initial begin
    logic [31:0]            rd;
    eth_udp_pkg::mac_addr_u mac_rd;
    eth_udp_pkg::mac_addr_u mac_exp;
    void'($urandom(SEED));
    rx        = '0;
    csr_req   = '0;
    rst       = 1'b1;
    exp_rec   = '0;
    load_table();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_irq("o_pkt_recv", 1'b0, pkt_recv);
    check_record();

    mac_exp.addr = MY_MAC;
    csr_write(eth_udp_pkg::CSR_MAC_LOW, {8'h00, mac_exp.half.low});
    csr_write(eth_udp_pkg::CSR_MAC_HIGH, {8'h00, mac_exp.half.high});
    csr_write(eth_udp_pkg::CSR_IP, MY_IP);
    read_mac(eth_udp_pkg::CSR_MAC_LOW, eth_udp_pkg::CSR_MAC_HIGH, mac_rd);
    check_mac("local MAC", mac_exp, mac_rd);
    csr_read(eth_udp_pkg::CSR_IP, rd);
    check_ip("local IP", MY_IP, rd);

    for (int i = 0; i < NUM_ROWS; i++) begin
      build_frame(rows[i]);
      send_frame(rows[i].err);
      check_irq_timing(rows[i].accept);
      if (rows[i].accept) begin
        exp_rec.src_mac.addr = rows[i].src_mac;
        exp_rec.src_ip       = rows[i].src_ip;
        exp_rec.udp_len      = rows[i].udp_len;
      end
      check_record();
      csr_read(eth_udp_pkg::CSR_IRQ, rd);
      check_irq("CSR_IRQ bit 0", rows[i].accept, rd[0]);
      csr_write(eth_udp_pkg::CSR_IRQ, 32'h1);
      check_irq("o_pkt_recv", 1'b0, pkt_recv);
      csr_read(eth_udp_pkg::CSR_IRQ, rd);
      check_irq("CSR_IRQ bit 0", 1'b0, rd[0]);
    end

    // Unmapped offsets, then writes to read-only record registers
    csr_read(6'h20, rd);
    check_rdata("o_csr_rsp.rdata at 0x20", 32'h0, rd);
    csr_read(6'h3C, rd);
    check_rdata("o_csr_rsp.rdata at 0x3C", 32'h0, rd);
    csr_write(eth_udp_pkg::CSR_RECV_MAC_LOW, 32'h00AA_BBCC);
    csr_write(eth_udp_pkg::CSR_RECV_IP, 32'hDEAD_BEEF);
    csr_write(eth_udp_pkg::CSR_RECV_UDP_LEN, 32'h0000_FFFF);
    check_record();

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
design/eth_udp_pkg.sv
design/eth_frame_parser.sv
design/ip_udp_parser.sv
design/udp_rx_capture.sv
design/eth_csr.sv
design/eth_udp_rx_top.sv
dv/eth_udp_rx_assertions.sv
dv/tb_eth_udp_rx.sv

/* Bender.yml */
package:
  name: eth_udp_rx

sources:
  - design/eth_udp_pkg.sv
  - design/eth_frame_parser.sv
  - design/ip_udp_parser.sv
  - design/udp_rx_capture.sv
  - design/eth_csr.sv
  - design/eth_udp_rx_top.sv
  - target: test
    files:
      - dv/eth_udp_rx_assertions.sv
      - dv/tb_eth_udp_rx.sv
